/* hw/cam_line_pkg.sv */
package cam_line_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // line geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int h_act    = 16;                   // active pixels per line
    localparam int v_act    = 720;                  // rows per frame
    localparam int coord_w  = 11;                   // row and col field width
    localparam int pix_aw   = $clog2(h_act);        // line memory address width

    localparam logic [pix_aw-1:0] last_pix = pix_aw'(h_act - 1);

    // idle cycles between cam1 readout and cam2 trigger
    localparam int gap_wait = h_act;
    localparam int gap_cw   = $clog2(gap_wait + 1);

    localparam logic [4:0] cam1_id = 5'b10000;
    localparam logic [4:0] cam2_id = 5'b01000;

    ////////////////////////////////////////////////////////////////////////////
    // stream words
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic               frame_start;
        logic               line_valid;
        logic               pix_valid;
        logic [coord_w-1:0] row;
        logic [coord_w-1:0] col;
        logic [23:0]        pix;            // r in [23:16], b in [7:0]
    } cam_pack_t;

    typedef struct packed {
        logic [7:0]         data;
        logic [coord_w-1:0] row;
        logic               last;           // final byte of the line
    } line_byte_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } pkt_byte_t;

endpackage : cam_line_pkg

/* hw/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer import cam_line_pkg::*; (
    input  logic       rclk,
    input  logic       rstn,
    input  cam_pack_t  cam_pack,
    input  logic       cap_trig,
    output logic       busy,
    output logic       error,
    output line_byte_t rd,
    output logic       rd_valid,
    input  logic       rd_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_arm,                                 // waiting for col 0
        st_cap,
        st_read
    } state_t;

    state_t             state;
    logic [23:0]        mem [h_act];
    logic [pix_aw-1:0]  wr_ptr;
    logic [pix_aw-1:0]  rd_ptr;
    logic [1:0]         byte_sel;               // 0 r, 1 g, 2 b
    logic [coord_w-1:0] row_q;
    logic [23:0]        rd_pix;
    logic               pix_in;
    logic               wr_en;
    logic               rd_take;

    assign pix_in  = cam_pack.pix_valid && cam_pack.line_valid;
    assign wr_en   = pix_in && ((state == st_cap) ||
                                (state == st_arm && cam_pack.col == '0));
    assign rd_take = rd_valid && rd_ready;

    assign busy     = (state != st_idle);
    assign rd_valid = (state == st_read);

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state    <= st_idle;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            byte_sel <= '0;
            error    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    wr_ptr <= '0;
                    if (cap_trig) begin
                        state <= st_arm;
                    end
                end
                st_arm: begin
                    if (wr_en) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        state  <= st_cap;
                    end
                end
                st_cap: begin
                    if (!cam_pack.line_valid) begin
                        error  <= 1'b1;         // short line, drop it and rearm
                        wr_ptr <= '0;
                        state  <= st_arm;
                    end else if (wr_en) begin
                        if (wr_ptr == last_pix) begin
                            rd_ptr   <= '0;
                            byte_sel <= '0;
                            state    <= st_read;
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                        end
                    end
                end
                st_read: begin
                    if (rd_take) begin
                        if (byte_sel == 2'd2) begin
                            byte_sel <= '0;
                            if (rd_ptr == last_pix) begin
                                state <= st_idle;
                            end else begin
                                rd_ptr <= rd_ptr + 1'b1;
                            end
                        end else begin
                            byte_sel <= byte_sel + 1'b1;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // line storage and row tag
    always_ff @(posedge rclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= cam_pack.pix;
        end
        if (wr_en && state == st_arm) begin
            row_q <= cam_pack.row;
        end
    end

    assign rd_pix = mem[rd_ptr];

    always_comb begin
        rd.row  = row_q;
        rd.last = (rd_ptr == last_pix) && (byte_sel == 2'd2);
        case (byte_sel)
            2'd0:    rd.data = rd_pix[23:16];
            2'd1:    rd.data = rd_pix[15:8];
            default: rd.data = rd_pix[7:0];
        endcase
    end

    a_rd_stable: assert property (@(posedge rclk) disable iff (!rstn)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd));

    a_no_trig_busy: assert property (@(posedge rclk) disable iff (!rstn)
        cap_trig |-> !busy);

endmodule : line_buffer

/* hw/line_swap_buffer.sv */
`timescale 1ns/1ps

module line_swap_buffer import cam_line_pkg::*; (
    input  logic       rclk,
    input  logic       rstn,
    input  logic       trig,
    input  cam_pack_t  cam1_pack,
    input  cam_pack_t  cam2_pack,
    output line_byte_t line,
    output logic       line_valid,
    input  logic       line_ready,
    output logic [4:0] cam_id,
    output logic       error
);

    typedef enum logic [2:0] {
        s_idle,
        s_trig_cam1,
        s_wait_cam1,
        s_gap,
        s_trig_cam2,
        s_wait_cam2
    } state_t;

    state_t            state;
    logic [gap_cw-1:0] gap_cnt;
    logic              cam_sel;                 // 0 serves cam1, 1 serves cam2

    logic       b1_trig, b1_busy, b1_err, b1_valid, b1_ready;
    logic       b2_trig, b2_busy, b2_err, b2_valid, b2_ready;
    line_byte_t b1_rd, b2_rd;

    assign b1_trig = (state == s_trig_cam1);
    assign b2_trig = (state == s_trig_cam2);

    line_buffer u_buf1 (
        .rclk     (rclk),
        .rstn     (rstn),
        .cam_pack (cam1_pack),
        .cap_trig (b1_trig),
        .busy     (b1_busy),
        .error    (b1_err),
        .rd       (b1_rd),
        .rd_valid (b1_valid),
        .rd_ready (b1_ready)
    );

    line_buffer u_buf2 (
        .rclk     (rclk),
        .rstn     (rstn),
        .cam_pack (cam2_pack),
        .cap_trig (b2_trig),
        .busy     (b2_busy),
        .error    (b2_err),
        .rd       (b2_rd),
        .rd_valid (b2_valid),
        .rd_ready (b2_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // output steering
    ////////////////////////////////////////////////////////////////////////////

    assign b1_ready   = !cam_sel && line_ready;
    assign b2_ready   = cam_sel && line_ready;
    assign line       = cam_sel ? b2_rd : b1_rd;
    assign line_valid = cam_sel ? b2_valid : b1_valid;
    assign cam_id     = cam_sel ? cam2_id : cam1_id;
    assign error      = b1_err || b2_err;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state   <= s_idle;
            gap_cnt <= '0;
            cam_sel <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    cam_sel <= 1'b0;
                    if (trig) begin
                        state <= s_trig_cam1;   // pulses outside idle are dropped
                    end
                end
                s_trig_cam1: state <= s_wait_cam1;
                s_wait_cam1: begin
                    if (!b1_busy) begin
                        gap_cnt <= '0;
                        state   <= s_gap;
                    end
                end
                s_gap: begin
                    if (gap_cnt == gap_cw'(gap_wait - 1)) begin
                        cam_sel <= 1'b1;
                        state   <= s_trig_cam2;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                s_trig_cam2: state <= s_wait_cam2;
                s_wait_cam2: begin
                    if (!b2_busy) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // only the selected buffer offers bytes and the two never hold a line together
    a_one_ready: assert property (@(posedge rclk) disable iff (!rstn)
        !(b1_valid && cam_sel) && !(b2_valid && !cam_sel) && !(b1_busy && b2_busy));

endmodule : line_swap_buffer

/* hw/line_packetizer.sv */
`timescale 1ns/1ps

module line_packetizer import cam_line_pkg::*; (
    input  logic       rclk,
    input  logic       rstn,
    input  line_byte_t line,
    input  logic       line_valid,
    output logic       line_ready,
    input  logic [4:0] cam_id,
    output pkt_byte_t  pkt,
    output logic       pkt_valid,
    input  logic       pkt_ready
);

    typedef enum logic [1:0] {
        ph_cam,
        ph_row_hi,
        ph_row_lo,
        ph_data
    } phase_t;

    phase_t    phase;
    pkt_byte_t next_byte;
    logic      slot_free;
    logic      load;

    // header bytes wait for the first line byte so row and cam_id are valid
    assign slot_free  = !pkt_valid || pkt_ready;
    assign load       = slot_free && line_valid;
    assign line_ready = slot_free && (phase == ph_data);

    always_comb begin
        next_byte.last = 1'b0;
        case (phase)
            ph_cam:    next_byte.data = {3'b000, cam_id};
            ph_row_hi: next_byte.data = {5'b00000, line.row[10:8]};
            ph_row_lo: next_byte.data = line.row[7:0];
            default: begin
                next_byte.data = line.data;
                next_byte.last = line.last;
            end
        endcase
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            phase     <= ph_cam;
            pkt_valid <= 1'b0;
        end else if (slot_free) begin
            pkt_valid <= line_valid;
            if (line_valid) begin
                case (phase)
                    ph_cam:    phase <= ph_row_hi;
                    ph_row_hi: phase <= ph_row_lo;
                    ph_row_lo: phase <= ph_data;
                    default:   phase <= line.last ? ph_cam : ph_data;
                endcase
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (load) begin
            pkt <= next_byte;
        end
    end

    a_pkt_hold: assert property (@(posedge rclk) disable iff (!rstn)
        pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt));

endmodule : line_packetizer

/* hw/cam_line_top.sv */
`timescale 1ns/1ps

module cam_line_top import cam_line_pkg::*; (
    input  logic      rclk,
    input  logic      rstn,
    input  logic      trig,
    input  cam_pack_t cam1_pack,
    input  cam_pack_t cam2_pack,
    output pkt_byte_t pkt,
    output logic      pkt_valid,
    input  logic      pkt_ready,
    output logic      error
);

    line_byte_t line;
    logic       line_valid;
    logic       line_ready;
    logic [4:0] cam_id;

    line_swap_buffer u_swap (
        .rclk       (rclk),
        .rstn       (rstn),
        .trig       (trig),
        .cam1_pack  (cam1_pack),
        .cam2_pack  (cam2_pack),
        .line       (line),
        .line_valid (line_valid),
        .line_ready (line_ready),
        .cam_id     (cam_id),
        .error      (error)
    );

    line_packetizer u_pkt (
        .rclk       (rclk),
        .rstn       (rstn),
        .line       (line),
        .line_valid (line_valid),
        .line_ready (line_ready),
        .cam_id     (cam_id),
        .pkt        (pkt),
        .pkt_valid  (pkt_valid),
        .pkt_ready  (pkt_ready)
    );

endmodule : cam_line_top

/* testbench/tb_cam_line.sv */
`timescale 1ns/1ps

module tb_cam_line import cam_line_pkg::*; ();

    localparam int pkt_len = 3 + 3 * h_act;

    logic      rclk, rstn, trig, pkt_ready, error;
    cam_pack_t cam1_pack, cam2_pack;
    pkt_byte_t pkt;
    logic      pkt_valid;

    int seed, fd, limit, cyc, pkt_cnt, byte_idx, err_cnt, t_err;
    int pass_cnt, fail_cnt, row1, row_now, last1_cyc, ready_mode, short_req, short_pending;
    int tnum[$], ntrig[$], rmode[$], sflag[$], xerr[$];
    int col[2], row[2], blank[2], len[2];
    bit in_line[2];
    string s;

    cam_line_top uut (.*);

    initial begin
        rclk = 1'b0;
        forever #50 rclk = ~rclk;
    end

    // free-running cameras, R = col, G = row low byte, B = camera number
    always @(negedge rclk) begin
        cam_pack_t p [2];
        for (int i = 0; i < 2; i++) begin
            p[i] = '0;
            if (in_line[i]) begin
                p[i].frame_start = (row[i] == 0) && (col[i] == 0);
                p[i].line_valid  = 1'b1;
                p[i].pix_valid   = 1'b1;
                p[i].row         = 11'(row[i]);
                p[i].col         = 11'(col[i]);
                p[i].pix         = {8'(col[i]), 8'(row[i]), 8'(i + 1)};
                col[i]++;
                if (col[i] == len[i]) begin
                    in_line[i] = 1'b0;
                    blank[i]   = 4;
                    row[i]     = (row[i] + 1) % v_act;
                end
            end else begin
                blank[i] = blank[i] - 1;
                if (blank[i] == 0) begin
                    in_line[i] = 1'b1;
                    col[i]     = 0;
                    len[i]     = h_act;
                    if (i == 0 && short_pending != 0) begin
                        len[i]        = h_act / 2;  // cut line, buffer is armed by now
                        short_pending = 0;
                    end
                end
            end
        end
        cam1_pack <= p[0];
        cam2_pack <= p[1];
        if (ready_mode != 0) pkt_ready <= 1'(($random(seed)));
        else pkt_ready <= 1'b1;
    end

    task automatic report_mismatch(string name, int exp, int got);
        $display("** Error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        err_cnt++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // scoreboard and watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge rclk) begin
        int exp, p;
        cyc++;
        if (trig && short_req != 0) short_pending = 1;     // next cam1 line is cut
        if (limit > 0 && cyc > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end else if (rstn && pkt_valid && pkt_ready) begin
            p = (byte_idx - 3) / 3;
            if (byte_idx == 0) begin
                exp = (pkt_cnt % 2 == 0) ? 16 : 8;
                if (exp == 8 && cyc - last1_cyc < gap_wait) begin
                    $display("cam2 packet started %0d cycles after cam1 ended",
                             cyc - last1_cyc);
                    err_cnt++;
                end
            end else if (byte_idx == 1) begin
                row_now = pkt.data << 8;
            end else if (byte_idx == 2) begin
                row_now += pkt.data;
                if (row_now >= v_act) report_mismatch("header row", v_act - 1, row_now);
                if (pkt_cnt % 2 == 0) row1 = row_now;
                else if ((row_now - row1 + v_act) % v_act >= v_act / 2) begin
                    $display("cam2 row %0d is earlier than cam1 row %0d", row_now, row1);
                    err_cnt++;
                end
            end else if ((byte_idx - 3) % 3 == 0) exp = p;
            else if ((byte_idx - 3) % 3 == 1) exp = row_now % 256;
            else exp = pkt_cnt % 2 + 1;
            if (byte_idx != 1 && byte_idx != 2 && pkt.data != 8'(exp))
                report_mismatch("pkt.data", exp, pkt.data);
            if (pkt.last != (byte_idx == pkt_len - 1))
                report_mismatch("pkt.last", byte_idx == pkt_len - 1, pkt.last);
            byte_idx++;
            if (pkt.last || byte_idx == pkt_len) begin
                if (pkt_cnt % 2 == 0) last1_cyc = cyc;
                byte_idx = 0;
                pkt_cnt++;
            end
        end
    end

    initial begin
        seed = 74942;
        rstn = 1'b0;
        trig = 1'b0;
        pkt_ready = 1'b0;
        cam1_pack = '0;
        cam2_pack = '0;
        blank = '{4, 4};
        fd = $fopen("testbench/line_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            err_cnt++;
        end else begin
            while ($fgets(s, fd) > 0) begin
                int a, b, c, d, e;
                if (s.len() > 1 && s[0] != "#" &&
                    $sscanf(s, "%d %d %d %d %d", a, b, c, d, e) == 5) begin
                    tnum.push_back(a);
                    ntrig.push_back(b);
                    rmode.push_back(c);
                    sflag.push_back(d);
                    xerr.push_back(e);
                    limit += 320 + b * (2 * h_act * 8 + gap_wait + v_act);  // reset and settle too
                end
            end
            $fclose(fd);
        end
        for (int k = 0; k < tnum.size(); k++) begin
            @(negedge rclk);
            rstn = 1'b0;
            ready_mode = rmode[k];
            repeat (10) @(negedge rclk);
            pkt_cnt  = 0;
            byte_idx = 0;
            t_err    = err_cnt;
            rstn = 1'b1;
            for (int t = 0; t < ntrig[k]; t++) begin
                short_req = (t == 0) ? sflag[k] : 0;
                trig = 1'b1;
                @(negedge rclk);
                trig = 1'b0;
                short_req = 0;
                repeat (4) @(negedge rclk);
                trig = 1'b1;                            // extra pulse while busy
                @(negedge rclk);
                trig = 1'b0;
                wait (pkt_cnt >= 2 * (t + 1));
                repeat (3) @(negedge rclk);
            end
            repeat (300) @(negedge rclk);
            if (pkt_cnt != 2 * ntrig[k]) report_mismatch("packet count", 2 * ntrig[k], pkt_cnt);
            if (error != 1'(xerr[k])) report_mismatch("error", xerr[k], error);
            if (err_cnt == t_err) pass_cnt++;
            else fail_cnt++;
            $display("test %0d: %s, %0d packets", tnum[k], (err_cnt == t_err) ? "ok" : "bad",
                     pkt_cnt);
        end
        $display("tests ok %0d, tests bad %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_cam_line

/* testbench/line_patterns.txt */
# columns: test number, trigger count, ready mode (0 always, 1 random),
# short cam1 line flag, expected error flag
1 1 0 0 0
2 3 0 0 0
3 2 1 0 0
4 4 1 0 0
5 1 0 1 1
6 2 1 1 1

/* flist.f */
hw/cam_line_pkg.sv
hw/line_buffer.sv
hw/line_swap_buffer.sv
hw/line_packetizer.sv
hw/cam_line_top.sv
testbench/tb_cam_line.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert -f flist.f --top-module tb_cam_line \
    -o sim_cam_line > build.log 2>&1 &&
./obj_dir/sim_cam_line > sim.log 2>&1 || { echo "build or run failed"; exit 1; }
grep -q "TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } ||
grep -q "TESTS PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation ok"
